//--- rtl/hex_pkg.sv
// screen geometry of the hex dump
// background palette indexed by nibble value
// stage structs for glyph and pixel links
package hex_pkg;

  localparam int cols = 16;      // digits per character row
  localparam int rows = 8;       // character rows
  localparam int scanlines = 8;  // scanlines per glyph
  localparam int glyph_w = 5;    // font columns, one gap column follows

  localparam int frame_pixels = 6144; // 96 x 64

  localparam logic [7:0] white = 8'hFF; // glyph foreground

  // rrrgggbb style colours, dark first then light
  localparam logic [7:0] palette [16] = '{
    8'h00, 8'h40, 8'h44, 8'h48, 8'h08, 8'h05, 8'h01, 8'h21,
    8'h45, 8'h80, 8'h84, 8'h90, 8'h10, 8'h0A, 8'h02, 8'h42
  };

  typedef struct packed {
    logic [glyph_w-1:0] rowbits; // bit 0 is the leftmost pixel
    logic [7:0]         bg;      // background colour
    logic               first;   // first glyph of a frame
  } glyph_t;

  typedef struct packed {
    logic [7:0] color;
    logic       first; // pixel 0 of a frame
  } pixel_t;

endpackage

//--- rtl/data_snapshot.sv
// hold filter on en
// data register sampled at frame start while en is held
`timescale 1ns/1ps

module data_snapshot #(
  parameter int data_bits = 64,
  parameter int hold_bits = 20
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  logic [data_bits-1:0] data,
  input  logic                 frame_start, // one cycle, from glyph_fetch
  output logic [data_bits-1:0] shown_data   // stable for the whole frame
);

  logic [hold_bits-1:0] hold_cnt; // consecutive cycles with en high
  logic                 go;

  // msb set means en has been held long enough
  assign go = hold_cnt[hold_bits-1];

  // saturates once the msb is reached, any low cycle restarts it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      hold_cnt <= '0;
    else if (!en)
      hold_cnt <= '0;
    else if (!go)
      hold_cnt <= hold_cnt + 1'b1;
  end

  // new word shows up the cycle after frame_start
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      shown_data <= '0; // first frame shows zeros
    else if (frame_start && go)
      shown_data <= data;
    // otherwise the screen stays frozen
  end

endmodule

//--- rtl/glyph_fetch.sv
// character, scanline and row counters
// nibble select, font rom and palette lookup
// sender side of the glyph req/ack link
`timescale 1ns/1ps

module glyph_fetch #(
  parameter int data_bits = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [data_bits-1:0] shown_data,
  output logic                 frame_start,
  output logic                 glyph_req,
  output hex_pkg::glyph_t      glyph,
  input  logic                 glyph_ack
);

  localparam int digits = data_bits / 4; // valid digit indices

  localparam logic [3:0] col_last = 4'(hex_pkg::cols - 1);
  localparam logic [2:0] scan_last = 3'(hex_pkg::scanlines - 1);
  localparam logic [2:0] row_last = 3'(hex_pkg::rows - 1);

  localparam logic [1:0] st_addr = 2'd0; // register digit index
  localparam logic [1:0] st_read = 2'd1; // rom and palette read
  localparam logic [1:0] st_req = 2'd2;  // req high, wait for ack
  localparam logic [1:0] st_wait = 2'd3; // wait for ack low

  logic [1:0]                  state;
  logic [3:0]                  col;
  logic [2:0]                  scan;
  logic [2:0]                  row;
  logic                        at_origin;
  logic [6:0]                  idx_q;   // digit index of current glyph
  logic [2:0]                  scan_q;
  logic                        first_q;
  logic [data_bits-1:0]        shifted;
  logic [3:0]                  nib;
  logic [hex_pkg::glyph_w-1:0] font [0:127]; // 16 glyphs x 8 scanlines

  initial
  begin
    $readmemb("rtl/font_rom.mem", font);
  end

  assign at_origin = (col == '0) && (scan == '0) && (row == '0);
  assign frame_start = (state == st_addr) && at_origin;

  // msb nibble on the left, so the column runs backwards
  assign shifted = shown_data >> {idx_q, 2'b00};
  assign nib = shifted[3:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_addr;
      col <= '0;
      scan <= '0;
      row <= '0;
      glyph_req <= 1'b0;
    end
    else
    begin
      case (state)
        st_addr:
        begin
          state <= st_read;
          if (col == col_last) // column fastest, then scanline, then row
          begin
            col <= '0;
            if (scan == scan_last)
            begin
              scan <= '0;
              row <= (row == row_last) ? '0 : row + 3'd1; // wraps at end of frame
            end
            else
              scan <= scan + 3'd1;
          end
          else
            col <= col + 4'd1;
        end
        st_read:
        begin
          glyph_req <= 1'b1; // glyph word is loaded on this same edge
          state <= st_req;
        end
        st_req:
        begin
          if (glyph_ack)
          begin
            glyph_req <= 1'b0;
            state <= st_wait;
          end
        end
        default:
        begin
          if (!glyph_ack)
            state <= st_addr; // handshake complete
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_addr)
    begin
      idx_q <= {row, ~col}; // row*16 + (15 - col)
      scan_q <= scan;
      first_q <= at_origin;
    end
    if (state == st_read)
    begin
      if (idx_q < digits)
        glyph <= '{rowbits: font[{nib, scan_q}], bg: hex_pkg::palette[nib], first: first_q};
      else
        glyph <= '{rowbits: '0, bg: 8'h00, first: first_q}; // beyond data, blank
    end
  end

endmodule

//--- rtl/pixel_shift.sv
// glyph receiver and pixel serializer
// six pixels per glyph, each on its own four-phase cycle
`timescale 1ns/1ps

module pixel_shift (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            glyph_req,
  input  hex_pkg::glyph_t glyph,
  output logic            glyph_ack,
  output logic            pix_req,
  output hex_pkg::pixel_t pix,
  input  logic            pix_ack
);

  localparam int steps = hex_pkg::glyph_w + 1; // font columns plus gap

  logic [2:0]       cnt;   // pixels left, 0 means empty
  logic             drain; // req dropped, waiting for ack low
  logic [steps-1:0] sh;    // lsb is the pixel on the link
  logic [7:0]       bg_q;
  logic             first_q;
  logic             load;

  // take a glyph only with nothing left to shift
  assign load = (cnt == '0) && glyph_req && !glyph_ack;

  assign pix.color = sh[0] ? hex_pkg::white : bg_q;
  assign pix.first = first_q && (cnt == 3'(steps)); // first pixel of a first glyph

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      glyph_ack <= 1'b0;
      pix_req <= 1'b0;
      drain <= 1'b0;
      cnt <= '0;
    end
    else
    begin
      if (load)
      begin
        glyph_ack <= 1'b1;
        cnt <= 3'(steps);
      end
      else if (!glyph_req)
        glyph_ack <= 1'b0;

      if (cnt != '0)
      begin
        if (!pix_req && !pix_ack && !drain)
          pix_req <= 1'b1; // pixel data already stable
        else if (pix_req && pix_ack)
        begin
          pix_req <= 1'b0;
          drain <= 1'b1;
        end
        else if (drain && !pix_ack)
        begin
          drain <= 1'b0;
          cnt <= cnt - 3'd1; // next pixel, both lines low
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      sh <= {1'b0, glyph.rowbits}; // gap column always background
      bg_q <= glyph.bg;
      first_q <= glyph.first;
    end
    else if (drain && !pix_ack)
      sh <= sh >> 1;
  end

endmodule

//--- rtl/hex_display.sv
// top of the hex dump pixel generator
// snapshot, glyph fetch and pixel shift in a row
`timescale 1ns/1ps

module hex_display #(
  parameter int data_bits = 64, // multiple of 4, up to 512
  parameter int hold_bits = 20  // en hold filter width
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  logic [data_bits-1:0] data,
  output logic                 pix_req,
  output hex_pkg::pixel_t      pix,
  input  logic                 pix_ack
);

  logic                 frame_start;
  logic [data_bits-1:0] shown_data;
  logic                 glyph_req;
  logic                 glyph_ack;
  hex_pkg::glyph_t      glyph;

  data_snapshot #(
    .data_bits(data_bits),
    .hold_bits(hold_bits)
  ) data_snapshot_i (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .data(data),
    .frame_start(frame_start),
    .shown_data(shown_data)
  );

  glyph_fetch #(
    .data_bits(data_bits)
  ) glyph_fetch_i (
    .clk(clk),
    .rst_n(rst_n),
    .shown_data(shown_data),
    .frame_start(frame_start),
    .glyph_req(glyph_req),
    .glyph(glyph),
    .glyph_ack(glyph_ack)
  );

  pixel_shift pixel_shift_i (
    .clk(clk),
    .rst_n(rst_n),
    .glyph_req(glyph_req),
    .glyph(glyph),
    .glyph_ack(glyph_ack),
    .pix_req(pix_req),
    .pix(pix),
    .pix_ack(pix_ack)
  );

endmodule

//--- bench/pixel_checker.sv
// reference model of the 96x64 hex dump screen
// compares every accepted pixel, tracks frames and per test error counts
`timescale 1ns/1ps

module pixel_checker #(
  parameter int data_bits = 72,
  parameter int hold_bits = 4,
  parameter int n_frames = 6
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 en,
  input  logic [data_bits-1:0] data,
  input  logic                 pix_req,
  input  hex_pkg::pixel_t      pix,
  input  logic                 pix_ack,
  output int                   frame_no,    // frame on the link or -1 before the first
  output int                   frames_done,
  output int                   errors,
  output int                   tests_failed
);

  localparam int digits = data_bits / 4;   // digits that carry data
  localparam int width = 96;               // pixels per scanline
  localparam int go_cycles = 1 << (hold_bits - 1);
  localparam int snap_point = hex_pkg::frame_pixels * 3 / 4; // inputs settled by now

  // background colours by nibble value
  localparam logic [7:0] pal [16] = '{
    8'h00, 8'h40, 8'h44, 8'h48, 8'h08, 8'h05, 8'h01, 8'h21,
    8'h45, 8'h80, 8'h84, 8'h90, 8'h10, 8'h0A, 8'h02, 8'h42
  };

  logic [4:0]           font [0:127];
  logic [data_bits-1:0] cur_data;  // word the frame on the link shows
  logic [data_bits-1:0] next_data; // word the next frame will show
  logic                 started;
  int                   hold;      // consecutive en high cycles up to go_cycles
  int                   count;     // accepted pixels in this frame
  int                   err_test [1:6];

  initial
  begin
    $readmemb("rtl/font_rom.mem", font);
  end

  // hold filter as seen by the design on each rising edge
  always @(posedge clk)
  begin
    if (!rst_n || !en)
      hold <= 0;
    else if (hold < go_cycles)
      hold <= hold + 1;
  end

  function automatic int digit_of(input int p);
    int x;
    int y;
    x = p % width;
    y = p / width;
    return (y / 8) * 16 + (15 - x / 6); // msb nibble on the left
  endfunction

  function automatic logic [7:0] expected_color(input int p, input logic [data_bits-1:0] shown);
    int         x;
    int         y;
    int         d;
    int         px;
    logic [3:0] nib;
    logic [4:0] line;
    x = p % width;
    y = p / width;
    px = x % 6;
    d = digit_of(p);
    if (d >= digits)
      return 8'h00; // unused digit stays blank
    nib = shown[4*d +: 4];
    line = font[nib * 8 + y % 8];
    if (px == 5)
      return pal[nib]; // gap column
    if (line[px])
      return 8'hFF;
    return pal[nib];
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "zeros after reset";
      2: return "random data with en high";
      3: return "en low freezes the frame";
      4: return "short en pulse ignored";
      5: return "frame length and first flag under back-pressure";
      default: return "unused digits stay blank";
    endcase
  endfunction

  task automatic note_error(input int t);
    err_test[t] = err_test[t] + 1;
    errors = errors + 1;
  endtask

  task automatic report_test(input int t);
    if (err_test[t] == 0)
      $display("test %0d %s: ok", t, test_name(t));
    else
    begin
      $display("test %0d %s: %0d errors", t, test_name(t), err_test[t]);
      tests_failed = tests_failed + 1;
    end
  endtask

  task automatic finish_frame();
    frames_done = frames_done + 1;
    if (frames_done <= 4)
      report_test(frames_done); // frames 0 to 3 carry tests 1 to 4
    if (frames_done == n_frames)
    begin
      report_test(5);
      report_test(6);
    end
  endtask

  task automatic check_pixel(input logic [7:0] got);
    logic [7:0] want;
    int         t;
    want = expected_color(count, cur_data);
    if (digit_of(count) >= digits)
      t = 6;
    else if (frame_no < 4)
      t = frame_no + 1;
    else
      t = 5;
    if (got !== want)
    begin
      $display("ERR %0t pix.color expected %02h got %02h (frame %0d pixel %0d)",
               $time, want, got, frame_no, count);
      note_error(t);
    end
  endtask

  task automatic take_pixel();
    if (pix.first)
    begin
      if (started && count != hex_pkg::frame_pixels)
      begin
        $display("frame %0d ended after %0d pixels instead of %0d",
                 frame_no, count, hex_pkg::frame_pixels);
        note_error(5);
        finish_frame();
      end
      started = 1'b1;
      count = 0;
      frame_no = frame_no + 1;
      cur_data = next_data;
    end
    else if (!started)
    begin
      $display("pixel accepted at %0t before any pixel with first set", $time);
      note_error(5);
      return;
    end
    else if (count >= hex_pkg::frame_pixels)
    begin
      $display("frame %0d runs past %0d pixels, first flag missing at %0t",
               frame_no, hex_pkg::frame_pixels, $time);
      note_error(5);
      return;
    end
    check_pixel(pix.color);
    count = count + 1;
    if (count == snap_point)
      next_data = (hold >= go_cycles) ? data : cur_data; // as loaded at the next frame start
    if (count == hex_pkg::frame_pixels)
      finish_frame();
  endtask

  // req and ack both high at mid cycle marks one accepted pixel
  always @(negedge clk)
  begin
    if (!rst_n)
    begin
      frame_no = -1;
      frames_done = 0;
      errors = 0;
      tests_failed = 0;
      count = 0;
      started = 1'b0;
      cur_data = '0;   // data register clears on reset
      next_data = '0;
      for (int t = 1; t <= 6; t++)
        err_test[t] = 0;
    end
    else if (pix_req && pix_ack)
      take_pixel();
  end

endmodule

//--- bench/tb_hex_display.sv
// testbench top for the hex display pixel generator
// clock, reset, xorshift stimulus, pix_ack responder, watchdog and summary
`timescale 1ns/1ps

module tb_hex_display;

  localparam int data_bits = 72;
  localparam int hold_bits = 4;
  localparam int n_frames = 6;
  localparam int limit_cycles = n_frames * hex_pkg::frame_pixels * 10;

  logic                 clk;
  logic                 rst_n;
  logic                 en;
  logic [data_bits-1:0] data;
  logic                 pix_req;
  hex_pkg::pixel_t      pix;
  logic                 pix_ack;

  logic [31:0] stim_state; // xorshift state for data and en
  logic [31:0] ack_state;  // xorshift state for ack delays
  logic [1:0]  ack_wait;
  int          frame_no;
  int          frames_done;
  int          errors;
  int          tests_failed;

  hex_display #(
    .data_bits(data_bits),
    .hold_bits(hold_bits)
  ) hex_display_i (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .data(data),
    .pix_req(pix_req),
    .pix(pix),
    .pix_ack(pix_ack)
  );

  pixel_checker #(
    .data_bits(data_bits),
    .hold_bits(hold_bits),
    .n_frames(n_frames)
  ) pixel_checker_i (
    .clk(clk),
    .rst_n(rst_n),
    .en(en),
    .data(data),
    .pix_req(pix_req),
    .pix(pix),
    .pix_ack(pix_ack),
    .frame_no(frame_no),
    .frames_done(frames_done),
    .errors(errors),
    .tests_failed(tests_failed)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic random_word(output logic [data_bits-1:0] value);
    logic [data_bits+31:0] acc;
    int                    i;
    acc = '0;
    for (i = 0; i < data_bits; i += 32)
    begin
      stim_state = xorshift32(stim_state);
      acc = {acc[data_bits-1:0], stim_state};
    end
    value = acc[data_bits-1:0];
  endtask

  // called early in frame f, sets up what frame f+1 shows
  task automatic drive_frame(input int f);
    logic [data_bits-1:0] value;
    int                   len;
    random_word(value);
    data <= value;
    case (f)
      0: en <= 1'b1; // next frame takes the new word
      1: en <= 1'b0; // word changes but the screen stays
      2:
      begin
        stim_state = xorshift32(stim_state);
        len = 1 + int'(stim_state % 7); // 1 to 7 cycles, below the hold limit
        en <= 1'b1;
        repeat (len) @(posedge clk);
        en <= 1'b0;
      end
      default: en <= 1'b1;
    endcase
  endtask

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // four-phase consumer, each edge of ack waits 0 to 3 cycles
  initial
  begin
    pix_ack = 1'b0;
    ack_wait = 2'd0;
    ack_state = xorshift32(32'd69);
    forever
    begin
      @(posedge clk);
      if (!rst_n)
        pix_ack <= 1'b0;
      else if (pix_req != pix_ack)
      begin
        if (ack_wait == 2'd0)
        begin
          pix_ack <= pix_req;
          ack_state = xorshift32(ack_state);
          ack_wait = ack_state[1:0];
        end
        else
          ack_wait = ack_wait - 2'd1;
      end
    end
  end

  initial
  begin
    rst_n = 1'b0;
    en = 1'b0;
    data = '0;
    stim_state = 32'd69;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int f = 0; f < n_frames - 1; f++)
    begin
      while (frame_no != f) // wait for pixel 0 of frame f
        @(posedge clk);
      drive_frame(f);
    end
    wait (frames_done == n_frames);
    @(posedge clk);
    $display("%0d frames, 6 tests, %0d tests failed, %0d errors",
             frames_done, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d frames done",
             limit_cycles, frames_done, n_frames);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- list.f
rtl/hex_pkg.sv
rtl/data_snapshot.sv
rtl/glyph_fetch.sv
rtl/pixel_shift.sv
rtl/hex_display.sv
bench/pixel_checker.sv
bench/tb_hex_display.sv

//--- run.sh
#!/bin/sh
# builds the hex display testbench with Verilator and runs it
# the simulation log decides the exit status
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_hex_display -f list.f \
  -o tb_hex_display > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_hex_display > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

//--- rtl/font_rom.mem
// glyph rows for digits 0 to F, 8 scanlines per digit, 5 bits per row
// bit 0 is the leftmost pixel, so each row reads mirrored
01110
10001
11001
10101
10011
10001
01110
00000
00100
00110
00100
00100
00100
00100
01110
00000
01110
10001
10000
01000
00100
00010
11111
00000
11111
01000
00100
01000
10000
10001
01110
00000
01000
01100
01010
01001
11111
01000
01000
00000
11111
00001
01111
10000
10000
10001
01110
00000
01100
00010
00001
01111
10001
10001
01110
00000
11111
10000
01000
00100
00010
00010
00010
00000
01110
10001
10001
01110
10001
10001
01110
00000
01110
10001
10001
11110
10000
01000
00110
00000
01110
10001
10001
11111
10001
10001
10001
00000
01111
10001
10001
01111
10001
10001
01111
00000
01110
10001
00001
00001
00001
10001
01110
00000
00111
01001
10001
10001
10001
01001
00111
00000
11111
00001
00001
01111
00001
00001
11111
00000
11111
00001
00001
01111
00001
00001
00001
00000
